// File: common/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W = 32;
    localparam int REG_W  = 5;
    localparam int OPC_W  = 6;
    localparam int IMM_W  = 16;

    // Main opcodes
    localparam logic [OPC_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPC_W-1:0] OP_BEQ   = 6'h04;
    localparam logic [OPC_W-1:0] OP_ADDI  = 6'h08;
    localparam logic [OPC_W-1:0] OP_SLTI  = 6'h0a;
    localparam logic [OPC_W-1:0] OP_ANDI  = 6'h0c;
    localparam logic [OPC_W-1:0] OP_ORI   = 6'h0d;
    localparam logic [OPC_W-1:0] OP_LB    = 6'h20;
    localparam logic [OPC_W-1:0] OP_LH    = 6'h21;
    localparam logic [OPC_W-1:0] OP_LW    = 6'h23;
    localparam logic [OPC_W-1:0] OP_SB    = 6'h28;
    localparam logic [OPC_W-1:0] OP_SH    = 6'h29;
    localparam logic [OPC_W-1:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [OPC_W-1:0] FN_ADD = 6'h20;
    localparam logic [OPC_W-1:0] FN_SUB = 6'h22;
    localparam logic [OPC_W-1:0] FN_AND = 6'h24;
    localparam logic [OPC_W-1:0] FN_OR  = 6'h25;
    localparam logic [OPC_W-1:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [4:0]       shamt;
        logic [OPC_W-1:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [IMM_W-1:0] imm;
    } i_fmt_t;

    // Same word seen as R-format or I-format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,
        ALU_SUB    = 2'b01,
        ALU_FUNCT  = 2'b10,
        ALU_OPCODE = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    typedef struct packed {
        logic    alu_src;
        alu_op_t alu_op;
        logic    reg_dst;
    } ex_ctrl_t;

    typedef struct packed {
        logic      branch;
        logic      mem_write;
        logic      mem_read;
        mem_size_t mem_size;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc4;
        instr_t            instr;
        logic [DATA_W-1:0] rd1;
        logic [DATA_W-1:0] rd2;
        logic [DATA_W-1:0] ext;
        logic [REG_W-1:0]  rt;
        logic [REG_W-1:0]  rd;
        ex_ctrl_t          ex;
        mem_ctrl_t         mem;
        wb_ctrl_t          wb;
    } id_ex_t;

    typedef struct packed {
        logic [DATA_W-1:0] alu_result;
        logic [REG_W-1:0]  wr_reg;
        logic [DATA_W-1:0] store_data;
        logic              branch_taken;
        logic [DATA_W-1:0] branch_target;
    } ex_result_t;

endpackage

// File: decode/decode_ctrl.sv
`timescale 1ns/100ps

module decode_ctrl
(
    input  mips_pkg::instr_t                i_instr,
    output mips_pkg::ex_ctrl_t              o_ex,
    output mips_pkg::mem_ctrl_t             o_mem,
    output mips_pkg::wb_ctrl_t              o_wb,
    output logic [mips_pkg::DATA_W-1:0]     o_ext
);

    logic [mips_pkg::IMM_W-1:0] imm;
    logic                       zero_ext;

    assign imm = i_instr.i.imm;

    // Logical immediates take zero extension
    assign zero_ext = (i_instr.i.opcode == mips_pkg::OP_ANDI) ||
                      (i_instr.i.opcode == mips_pkg::OP_ORI);

    assign o_ext = zero_ext ? {{(mips_pkg::DATA_W-mips_pkg::IMM_W){1'b0}}, imm}
                            : {{(mips_pkg::DATA_W-mips_pkg::IMM_W){imm[15]}}, imm};

    always_comb
    begin
        o_ex  = '0;
        o_mem = '0;
        o_wb  = '0;
        case (i_instr.r.opcode)
            mips_pkg::OP_RTYPE:
            begin
                o_ex.alu_op    = mips_pkg::ALU_FUNCT;
                o_ex.reg_dst   = 1'b1;
                o_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ADDI:
            begin
                o_ex.alu_src   = 1'b1;
                o_ex.alu_op    = mips_pkg::ALU_ADD;
                o_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_SLTI:
            begin
                o_ex.alu_src   = 1'b1;
                o_ex.alu_op    = mips_pkg::ALU_OPCODE;
                o_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALU_ADD;
                o_mem.mem_read  = 1'b1;
                o_wb.mem_to_reg = 1'b1;
                o_wb.reg_write  = 1'b1;
                if (i_instr.r.opcode == mips_pkg::OP_LB)
                    o_mem.mem_size = mips_pkg::SIZE_BYTE;
                else if (i_instr.r.opcode == mips_pkg::OP_LH)
                    o_mem.mem_size = mips_pkg::SIZE_HALF;
                else
                    o_mem.mem_size = mips_pkg::SIZE_WORD;
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = mips_pkg::ALU_ADD;
                o_mem.mem_write = 1'b1;
                if (i_instr.r.opcode == mips_pkg::OP_SB)
                    o_mem.mem_size = mips_pkg::SIZE_BYTE;
                else if (i_instr.r.opcode == mips_pkg::OP_SH)
                    o_mem.mem_size = mips_pkg::SIZE_HALF;
                else
                    o_mem.mem_size = mips_pkg::SIZE_WORD;
            end
            mips_pkg::OP_BEQ:
            begin
                o_ex.alu_op  = mips_pkg::ALU_SUB;
                o_mem.branch = 1'b1;
            end
            default:
            begin
                // Unknown opcode leaves a bubble
                o_ex = '0;
            end
        endcase
    end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/100ps

module reg_file
(
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic [mips_pkg::REG_W-1:0]      i_rs,
    input  logic [mips_pkg::REG_W-1:0]      i_rt,
    output logic [mips_pkg::DATA_W-1:0]     o_rd1,
    output logic [mips_pkg::DATA_W-1:0]     o_rd2,
    input  logic                            i_we,
    input  logic [mips_pkg::REG_W-1:0]      i_wr_reg,
    input  logic [mips_pkg::DATA_W-1:0]     i_wr_data
);

    logic [mips_pkg::DATA_W-1:0] regs [32];
    logic                        wr_en;

    // r0 is never written
    assign wr_en = i_we && (i_wr_reg != '0);

    function automatic logic [mips_pkg::DATA_W-1:0] read_port(
        input logic [mips_pkg::REG_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (wr_en && (i_wr_reg == addr))
            return i_wr_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

    // Write-through on both ports
    assign o_rd1 = read_port(i_rs);
    assign o_rd2 = read_port(i_rt);

endmodule

// File: execute/alu_exec.sv
`timescale 1ns/100ps

module alu_exec
(
    input  mips_pkg::id_ex_t        i_id_ex,
    output mips_pkg::ex_result_t    o_result
);

    localparam logic [2:0] ALU_FN_ADD = 3'd0;
    localparam logic [2:0] ALU_FN_SUB = 3'd1;
    localparam logic [2:0] ALU_FN_AND = 3'd2;
    localparam logic [2:0] ALU_FN_OR  = 3'd3;
    localparam logic [2:0] ALU_FN_SLT = 3'd4;

    logic [2:0]                  alu_fn;
    logic [mips_pkg::DATA_W-1:0] op_a;
    logic [mips_pkg::DATA_W-1:0] op_b;
    logic [mips_pkg::DATA_W-1:0] alu_out;

    // ALU control
    always_comb
    begin
        alu_fn = ALU_FN_ADD;
        case (i_id_ex.ex.alu_op)
            mips_pkg::ALU_ADD:
                alu_fn = ALU_FN_ADD;
            mips_pkg::ALU_SUB:
                alu_fn = ALU_FN_SUB;
            mips_pkg::ALU_FUNCT:
            begin
                case (i_id_ex.instr.r.funct)
                    mips_pkg::FN_SUB: alu_fn = ALU_FN_SUB;
                    mips_pkg::FN_AND: alu_fn = ALU_FN_AND;
                    mips_pkg::FN_OR:  alu_fn = ALU_FN_OR;
                    mips_pkg::FN_SLT: alu_fn = ALU_FN_SLT;
                    default:          alu_fn = ALU_FN_ADD;
                endcase
            end
            mips_pkg::ALU_OPCODE:
            begin
                case (i_id_ex.instr.i.opcode)
                    mips_pkg::OP_ANDI: alu_fn = ALU_FN_AND;
                    mips_pkg::OP_ORI:  alu_fn = ALU_FN_OR;
                    mips_pkg::OP_SLTI: alu_fn = ALU_FN_SLT;
                    default:           alu_fn = ALU_FN_ADD;
                endcase
            end
            default:
                alu_fn = ALU_FN_ADD;
        endcase
    end

    assign op_a = i_id_ex.rd1;
    assign op_b = i_id_ex.ex.alu_src ? i_id_ex.ext : i_id_ex.rd2;

    always_comb
    begin
        case (alu_fn)
            ALU_FN_SUB: alu_out = op_a - op_b;
            ALU_FN_AND: alu_out = op_a & op_b;
            ALU_FN_OR:  alu_out = op_a | op_b;
            ALU_FN_SLT: alu_out = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign o_result.alu_result = alu_out;
    assign o_result.wr_reg     = i_id_ex.ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;
    assign o_result.store_data = i_id_ex.rd2;

    // beq resolves here, offset is in words
    assign o_result.branch_taken  = i_id_ex.mem.branch && (i_id_ex.rd1 == i_id_ex.rd2);
    assign o_result.branch_target = i_id_ex.pc4 + {i_id_ex.ext[mips_pkg::DATA_W-3:0], 2'b00};

endmodule

// File: logic/id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  mips_pkg::id_ex_t    i_id,
    output mips_pkg::id_ex_t    o_ex
);

    // Whole decode bundle moves on every edge, no stall or flush
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            // All-zero bundle is a bubble
            o_ex <= '0;
        end
        else
        begin
            o_ex.pc4   <= i_id.pc4;
            o_ex.instr <= i_id.instr;
            o_ex.rd1   <= i_id.rd1;
            o_ex.rd2   <= i_id.rd2;
            o_ex.ext   <= i_id.ext;
            o_ex.rt    <= i_id.rt;
            o_ex.rd    <= i_id.rd;

            // Control for EX, MEM and WB
            o_ex.ex    <= i_id.ex;
            o_ex.mem   <= i_id.mem;
            o_ex.wb    <= i_id.wb;
        end
    end

endmodule

// File: logic/mips_id_ex_top.sv
`timescale 1ns/100ps

module mips_id_ex_top
(
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  mips_pkg::instr_t                i_instr,
    input  logic [mips_pkg::DATA_W-1:0]     i_pc4,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_W-1:0]      i_wb_reg,
    input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
    output mips_pkg::ex_result_t            o_result,
    output mips_pkg::mem_ctrl_t             o_mem_ctrl,
    output mips_pkg::wb_ctrl_t              o_wb_ctrl
);

    mips_pkg::ex_ctrl_t          dec_ex;
    mips_pkg::mem_ctrl_t         dec_mem;
    mips_pkg::wb_ctrl_t          dec_wb;
    logic [mips_pkg::DATA_W-1:0] dec_ext;
    logic [mips_pkg::DATA_W-1:0] rf_rd1;
    logic [mips_pkg::DATA_W-1:0] rf_rd2;
    mips_pkg::id_ex_t            id_bundle;
    mips_pkg::id_ex_t            ex_bundle;

    decode_ctrl u_decode_ctrl (
        .i_instr (i_instr),
        .o_ex    (dec_ex),
        .o_mem   (dec_mem),
        .o_wb    (dec_wb),
        .o_ext   (dec_ext)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rs      (i_instr.r.rs),
        .i_rt      (i_instr.r.rt),
        .o_rd1     (rf_rd1),
        .o_rd2     (rf_rd2),
        .i_we      (i_wb_we),
        .i_wr_reg  (i_wb_reg),
        .i_wr_data (i_wb_data)
    );

    // Decode bundle
    assign id_bundle.pc4   = i_pc4;
    assign id_bundle.instr = i_instr;
    assign id_bundle.rd1   = rf_rd1;
    assign id_bundle.rd2   = rf_rd2;
    assign id_bundle.ext   = dec_ext;
    assign id_bundle.rt    = i_instr.r.rt;
    assign id_bundle.rd    = i_instr.r.rd;
    assign id_bundle.ex    = dec_ex;
    assign id_bundle.mem   = dec_mem;
    assign id_bundle.wb    = dec_wb;

    id_ex_reg u_id_ex_reg (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_id     (id_bundle),
        .o_ex     (ex_bundle)
    );

    alu_exec u_alu_exec (
        .i_id_ex  (ex_bundle),
        .o_result (o_result)
    );

    assign o_mem_ctrl = ex_bundle.mem;
    assign o_wb_ctrl  = ex_bundle.wb;

endmodule

// File: src.f
common/mips_pkg.sv
decode/decode_ctrl.sv
decode/reg_file.sv
logic/id_ex_reg.sv
execute/alu_exec.sv
logic/mips_id_ex_top.sv
verification/id_ex_sva.sv
verification/tb_mips_id_ex.sv

// File: verification/id_ex_sva.sv
`timescale 1ns/100ps

module id_ex_sva
(
    input logic             i_clk,
    input logic             i_arst_n,
    input mips_pkg::id_ex_t i_ex
);

    // A single access per instruction
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_ex.mem.mem_read && i_ex.mem.mem_write))
        else $error("mem_read and mem_write set together");

    // Stores never write a register
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_ex.mem.mem_write && i_ex.wb.reg_write))
        else $error("mem_write set together with reg_write");

    assert property (@(posedge i_clk)
        !i_arst_n |-> (i_ex.ex == '0 && i_ex.mem == '0 && i_ex.wb == '0))
        else $error("control fields not cleared during reset");

endmodule

bind id_ex_reg id_ex_sva u_id_ex_sva (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ex     (o_ex)
);

// File: verification/tb_mips_id_ex.sv
`timescale 1ns/100ps

module tb_mips_id_ex;

    typedef struct packed {
        mips_pkg::ex_result_t res;
        mips_pkg::mem_ctrl_t  mem;
        mips_pkg::wb_ctrl_t   wb;
    } expect_t;

    localparam int MAX_CYCLES = 600;

    logic                       i_clk = 1'b0;
    logic                       i_arst_n;
    mips_pkg::instr_t           i_instr;
    logic [31:0]                i_pc4;
    logic                       i_wb_we;
    logic [4:0]                 i_wb_reg;
    logic [31:0]                i_wb_data;
    mips_pkg::ex_result_t       o_result;
    mips_pkg::mem_ctrl_t        o_mem_ctrl;
    mips_pkg::wb_ctrl_t         o_wb_ctrl;

    logic [31:0] shadow [32];
    logic [31:0] lfsr_state = 32'h031c_a8b7;
    logic [31:0] pc = 32'h0040_0004;
    expect_t     exp_next;
    expect_t     exp_cur;
    logic        exp_pending = 1'b0;
    logic        exp_valid = 1'b0;
    int          cycles = 0;
    int          err_result = 0;
    int          err_mem = 0;
    int          err_wb = 0;

    logic [5:0] op_table [13] = '{6'h00, 6'h08, 6'h0c, 6'h0d, 6'h0a, 6'h20, 6'h21,
                                  6'h23, 6'h28, 6'h29, 6'h2b, 6'h04, 6'h3f};
    logic [5:0] fn_table [5]  = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h2a};

    mips_id_ex_top dut (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_instr    (i_instr),
        .i_pc4      (i_pc4),
        .i_wb_we    (i_wb_we),
        .i_wb_reg   (i_wb_reg),
        .i_wb_data  (i_wb_data),
        .o_result   (o_result),
        .o_mem_ctrl (o_mem_ctrl),
        .o_wb_ctrl  (o_wb_ctrl)
    );

    always #10 i_clk = ~i_clk;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic mips_pkg::mem_size_t size_of(input logic [5:0] op);
        if (op == mips_pkg::OP_LB || op == mips_pkg::OP_SB)
            return mips_pkg::SIZE_BYTE;
        else if (op == mips_pkg::OP_LH || op == mips_pkg::OP_SH)
            return mips_pkg::SIZE_HALF;
        else
            return mips_pkg::SIZE_WORD;
    endfunction

    function automatic expect_t ref_model(input mips_pkg::instr_t ins, input logic [31:0] pc4,
                                          input logic [31:0] a, input logic [31:0] b);
        expect_t     e;
        logic [31:0] ext;
        logic [31:0] opb;
        logic [5:0]  op;
        logic [2:0]  fn;
        e = '0;
        op = ins.i.opcode;
        ext = {{16{ins.i.imm[15]}}, ins.i.imm};
        opb = b;
        fn = 3'd0;
        e.res.wr_reg = ins.i.rt;
        case (op)
            mips_pkg::OP_RTYPE:
            begin
                e.res.wr_reg = ins.r.rd;
                e.wb.reg_write = 1'b1;
                case (ins.r.funct)
                    mips_pkg::FN_SUB: fn = 3'd1;
                    mips_pkg::FN_AND: fn = 3'd2;
                    mips_pkg::FN_OR:  fn = 3'd3;
                    mips_pkg::FN_SLT: fn = 3'd4;
                    default:          fn = 3'd0;
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_SLTI:
            begin
                opb = ext;
                fn = (op == mips_pkg::OP_SLTI) ? 3'd4 : 3'd0;
                e.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI:
            begin
                ext = {16'h0, ins.i.imm};
                opb = ext;
                fn = (op == mips_pkg::OP_ANDI) ? 3'd2 : 3'd3;
                e.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW:
            begin
                opb = ext;
                e.mem.mem_read = 1'b1;
                e.mem.mem_size = size_of(op);
                e.wb.mem_to_reg = 1'b1;
                e.wb.reg_write = 1'b1;
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
            begin
                opb = ext;
                e.mem.mem_write = 1'b1;
                e.mem.mem_size = size_of(op);
            end
            mips_pkg::OP_BEQ:
            begin
                fn = 3'd1;
                e.mem.branch = 1'b1;
                e.res.branch_taken = (a == b);
            end
            default:
                e.res.branch_taken = 1'b0;
        endcase
        case (fn)
            3'd1:    e.res.alu_result = a - opb;
            3'd2:    e.res.alu_result = a & opb;
            3'd3:    e.res.alu_result = a | opb;
            3'd4:    e.res.alu_result = {31'h0, $signed(a) < $signed(opb)};
            default: e.res.alu_result = a + opb;
        endcase
        e.res.store_data = b;
        e.res.branch_target = pc4 + (ext << 2);
        return e;
    endfunction

    function automatic mips_pkg::instr_t make_r(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd);
        mips_pkg::instr_t ins;
        ins.r = '{mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
        return ins;
    endfunction

    function automatic mips_pkg::instr_t make_i(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        mips_pkg::instr_t ins;
        ins.i = '{op, rs, rt, imm};
        return ins;
    endfunction

    task automatic check_result(input mips_pkg::ex_result_t exp, input mips_pkg::ex_result_t act);
        if (act !== exp)
        begin
            $display("Fail o_result expected %h got %h", exp, act);
            err_result++;
        end
    endtask

    task automatic check_mem(input mips_pkg::mem_ctrl_t exp, input mips_pkg::mem_ctrl_t act);
        if (act !== exp)
        begin
            $display("Fail o_mem_ctrl expected %h got %h", exp, act);
            err_mem++;
        end
    endtask

    task automatic check_wb(input mips_pkg::wb_ctrl_t exp, input mips_pkg::wb_ctrl_t act);
        if (act !== exp)
        begin
            $display("Fail o_wb_ctrl expected %h got %h", exp, act);
            err_wb++;
        end
    endtask

    // Operands follow the write-through rule of the register file
    task automatic drive(input mips_pkg::instr_t ins, input logic we, input logic [4:0] wreg,
                         input logic [31:0] wdata);
        logic [31:0] a;
        logic [31:0] b;
        @(negedge i_clk);
        a = (we && wreg != 0 && wreg == ins.i.rs) ? wdata : shadow[ins.i.rs];
        b = (we && wreg != 0 && wreg == ins.i.rt) ? wdata : shadow[ins.i.rt];
        exp_next = ref_model(ins, pc, a, b);
        exp_pending = 1'b1;
        i_instr = ins;
        i_pc4 = pc;
        i_wb_we = we;
        i_wb_reg = wreg;
        i_wb_data = wdata;
        if (we && wreg != 0)
            shadow[wreg] = wdata;
        pc = pc + 32'd4;
    endtask

    always @(posedge i_clk)
    begin
        exp_cur <= exp_next;
        exp_valid <= exp_pending;
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge i_clk)
    begin
        if (exp_valid)
        begin
            check_result(exp_cur.res, o_result);
            check_mem(exp_cur.mem, o_mem_ctrl);
            check_wb(exp_cur.wb, o_wb_ctrl);
        end
    end

    initial
    begin
        mips_pkg::instr_t bubble;
        mips_pkg::instr_t ins;
        logic [31:0]      wb_en;
        logic [31:0]      wb_sel;
        bubble = make_i(6'h3f, 5'd0, 5'd0, 16'h0);
        for (int k = 0; k < 32; k++)
            shadow[k] = '0;
        i_arst_n = 1'b0;
        // Live controls at the input, so only reset can keep the outputs quiet
        i_instr = make_i(mips_pkg::OP_LW, 5'd0, 5'd0, 16'h0);
        i_pc4 = '0;
        i_wb_we = 1'b0;
        i_wb_reg = '0;
        i_wb_data = '0;
        repeat (3)
        begin
            @(negedge i_clk);
            check_mem('0, o_mem_ctrl);
            check_wb('0, o_wb_ctrl);
            if (o_result.branch_taken !== 1'b0)
            begin
                $display("Fail o_result.branch_taken expected 0 got %h", o_result.branch_taken);
                err_result++;
            end
            // beq r0, r0 would be taken without reset
            i_instr = make_i(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'h0);
        end
        i_arst_n = 1'b1;
        i_instr = bubble;
        drive(bubble, 1'b0, 5'd0, 32'h0);
        for (int k = 1; k < 32; k++)
            drive(bubble, 1'b1, k[4:0], rand_bits(32));
        // r0 stays zero, and a same-cycle write is forwarded
        drive(bubble, 1'b1, 5'd0, 32'hdead_beef);
        drive(make_r(mips_pkg::FN_ADD, 5'd0, 5'd0, 5'd9), 1'b0, 5'd0, 32'h0);
        drive(make_r(mips_pkg::FN_ADD, 5'd5, 5'd6, 5'd3), 1'b1, 5'd5, 32'h1234_5678);
        for (int k = 0; k < 5; k++)
            drive(make_r(fn_table[k], 5'd7, 5'd8, 5'd10), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_ADDI, 5'd4, 5'd11, 16'hfff0), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_SLTI, 5'd4, 5'd12, 16'h8000), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_ANDI, 5'd4, 5'd13, 16'hf0f0), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_ORI, 5'd4, 5'd14, 16'h8001), 1'b0, 5'd0, 32'h0);
        for (int k = 5; k < 11; k++)
            drive(make_i(op_table[k], 5'd2, 5'd15, 16'hff80), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_BEQ, 5'd6, 5'd6, 16'hfffc), 1'b0, 5'd0, 32'h0);
        drive(make_i(mips_pkg::OP_BEQ, 5'd6, 5'd7, 16'h0010), 1'b0, 5'd0, 32'h0);
        for (int n = 0; n < 400; n++)
        begin
            ins = rand_bits(32);
            ins.r.opcode = op_table[rand_bits(4) % 13];
            if (ins.r.opcode == mips_pkg::OP_RTYPE)
                ins.r.funct = fn_table[rand_bits(3) % 5];
            wb_en = rand_bits(1);
            wb_sel = rand_bits(5);
            drive(ins, wb_en[0], wb_sel[4:0], rand_bits(32));
        end
        drive(bubble, 1'b0, 5'd0, 32'h0);
        repeat (2)
            @(negedge i_clk);
        $display("Errors: result %0d, mem %0d, wb %0d", err_result, err_mem, err_wb);
        if (err_result + err_mem + err_wb == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
